//--- tcp_conn_top.f
+incdir+hw
hw/tcp_pkg.sv
hw/tcp_isn_lfsr.sv
hw/tcp_rx_classify.sv
hw/tcp_conn_fsm.sv
hw/tcp_seg_queue.sv
hw/tcp_conn_top.sv
verif/tcp_conn_asserts.sv
verif/tcp_conn_tb.sv

//--- verif/tcp_conn_tb.sv
`timescale 1ns/1ns
`include "tcp_params.svh"

module tcp_conn_tb;

  localparam int tmo_wait = 2 * `TCP_CONN_TIMEOUT;
  localparam logic [5:0] f_fin = 6'h01;
  localparam logic [5:0] f_syn = 6'h02;
  localparam logic [5:0] f_rst = 6'h04;
  localparam logic [5:0] f_psh = 6'h08;
  localparam logic [5:0] f_ack = 6'h10;

  logic                 clk;
  logic                 rst;
  logic [31:0]          loc_ip;
  tcp_pkg::tcp_ctl_t    ctl;
  logic                 rx_valid;
  tcp_pkg::tcp_seg_t    rx_seg;
  logic                 tx_credit;
  logic                 tx_valid;
  tcp_pkg::tcp_seg_t    tx_seg;
  tcp_pkg::tcp_status_t status;
  logic [31:0]          rem_seq;
  logic [31:0]          loc_seq;

  tcp_pkg::tcp_seg_t tx_q [$]; // Segments seen on the transmit side
  integer      seed = 32'h5bb3_f519;
  int          errors = 0;
  int          owed = 0;  // Credits not yet returned
  bit          hold = 1'b0;
  logic [31:0] l_seq;     // Next sequence the engine must use
  logic [31:0] r_seq;     // Next sequence of the peer
  logic [31:0] peer_ip;
  logic [15:0] peer_port;
  logic [15:0] our_port;

  tcp_conn_top DUT (.*);

  bind tcp_seg_queue tcp_conn_asserts asserts_inst (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_accept(req_accept),
    .tx_valid(tx_valid), .tx_credit(tx_credit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk) begin
    if (tx_valid) begin
      tx_q.push_back(tx_seg);
      owed++;
    end
  end

  // Credit return after a random gap
  initial begin
    int gap;
    tx_credit = 1'b0;
    forever begin
      @(negedge clk);
      if (owed > 0 && !hold) begin
        gap = $random(seed) & 7;
        repeat (gap + 1) @(posedge clk);
        #5 tx_credit = 1'b1;
        owed--;
        @(posedge clk);
        #5 tx_credit = 1'b0;
      end
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic send(input logic [5:0] flags, input logic [31:0] seq,
                      input logic [15:0] len, input logic [15:0] dst);
    @(posedge clk);
    #5;
    rx_seg           = '0;
    rx_seg.rem_ip    = peer_ip;
    rx_seg.src_port  = peer_port;
    rx_seg.dst_port  = dst;
    rx_seg.seq       = seq;
    rx_seg.ack       = l_seq; // Peer acknowledges all it got
    rx_seg.flags.raw = flags;
    rx_seg.len       = len;
    rx_seg.wnd       = 16'd2048;
    rx_valid         = 1'b1;
    @(posedge clk);
    #5 rx_valid = 1'b0;
  endtask

  task automatic expect_seg(input string what, input logic [5:0] flags,
                            input logic [31:0] seq, input logic [31:0] ack,
                            output tcp_pkg::tcp_seg_t s);
    int n;
    n = 0;
    s = '0;
    while (tx_q.size() == 0 && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (tx_q.size() == 0) begin
      errors++;
      $display("No %s segment was sent within 200 cycles", what);
    end else begin
      s = tx_q.pop_front();
      check({what, " flags"}, s.flags.raw, flags);
      if (!flags[1]) check({what, " seq"}, s.seq, seq); // ISN is the engine's own
      check({what, " ack"}, s.ack, ack);
      check({what, " len"}, s.len, '0);
      check({what, " src port"}, s.src_port, our_port);
      check({what, " dst port"}, s.dst_port, peer_port);
      check({what, " ip"}, s.rem_ip, peer_ip);
      check({what, " window"}, s.wnd, `TCP_WINDOW);
      check({what, " ttl"}, s.ttl, `TCP_TTL);
    end
  endtask

  task automatic wait_status(input tcp_pkg::tcp_status_t want, input int limit);
    int n;
    n = 0;
    while (status !== want && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (status !== want) begin
      errors++;
      $display("Status did not become %s within %0d cycles", want.name(), limit);
    end
  endtask

  task automatic expect_quiet(input string what, input int cycles);
    repeat (cycles) @(posedge clk);
    if (tx_q.size() != 0) begin
      errors++;
      $display("A segment was sent in answer to %s", what);
    end
  endtask

  task automatic open_active();
    tcp_pkg::tcp_seg_t s;
    @(posedge clk);
    #5;
    our_port     = 16'($random(seed));
    peer_port    = 16'($random(seed));
    peer_ip      = $random(seed);
    ctl          = '0;
    ctl.connect  = 1'b1;
    ctl.loc_port = our_port;
    ctl.rem_ip   = peer_ip;
    ctl.rem_port = peer_port;
    expect_seg("SYN", f_syn, '0, '0, s);
    l_seq = s.seq + 1; // SYN takes one number
    r_seq = $random(seed);
    send(f_syn | f_ack, r_seq, '0, our_port);
    r_seq = r_seq + 1;
    expect_seg("handshake ACK", f_ack, l_seq, r_seq, s);
    wait_status(tcp_pkg::tcp_connected, 20);
    check("loc_seq", loc_seq, l_seq);
  endtask

  initial begin
    tcp_pkg::tcp_seg_t s;
    logic [31:0]       exp_ack [$];
    logic [15:0]       len;
    int                n;
    int                afails;
    rst      = 1'b1;
    loc_ip   = 32'hc0a8_0001;
    ctl      = '0;
    rx_valid = 1'b0;
    rx_seg   = '0;
    repeat (16) @(posedge clk);
    #5 rst = 1'b0;

    ////////////////////
    // Active open and data
    open_active();
    repeat (4) begin
      len = 16'(($random(seed) & 32'h3ff) + 1);
      send(f_psh | f_ack, r_seq, len, our_port);
      r_seq = r_seq + len;
      expect_seg("data ACK", f_ack, l_seq, r_seq, s);
      check("rem_seq", rem_seq, r_seq);
    end
    send(f_psh | f_ack, r_seq, 16'd100, our_port + 1'b1);
    expect_quiet("data to a wrong port", 20);
    check("rem_seq after wrong port", rem_seq, r_seq);

    ////////////////////
    // Credit back-pressure
    n = 0;
    while (owed != 0 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (owed != 0) begin
      errors++;
      $display("Credits were not returned before the hold");
    end
    @(posedge clk);
    #5 hold = 1'b1;
    repeat (`TCP_TX_CREDITS + `TCP_SEG_QUEUE_DEPTH) begin
      len = 16'(($random(seed) & 32'h3ff) + 1);
      send(f_psh | f_ack, r_seq, len, our_port);
      r_seq = r_seq + len;
      exp_ack.push_back(r_seq);
      repeat (8) @(posedge clk);
    end
    check("segments sent without credit", tx_q.size(), `TCP_TX_CREDITS);
    @(posedge clk);
    #5 hold = 1'b0;
    while (exp_ack.size() != 0) expect_seg("held ACK", f_ack, l_seq, exp_ack.pop_front(), s);

    ////////////////////
    // Active close
    @(posedge clk);
    #5 ctl.connect = 1'b0;
    expect_seg("FIN-ACK", f_fin | f_ack, l_seq, r_seq, s);
    l_seq = l_seq + 1;
    send(f_ack, r_seq, '0, our_port);
    send(f_fin | f_ack, r_seq, '0, our_port);
    r_seq = r_seq + 1;
    expect_seg("last ACK", f_ack, l_seq, r_seq, s);
    wait_status(tcp_pkg::tcp_closed, 20);
    check("loc_seq after close", loc_seq, 32'h0); // Control block clears

    ////////////////////
    // Passive open and close
    @(posedge clk);
    #5;
    our_port     = 16'($random(seed));
    peer_port    = 16'($random(seed));
    peer_ip      = $random(seed);
    r_seq        = $random(seed);
    ctl          = '0;
    ctl.listen   = 1'b1;
    ctl.loc_port = our_port;
    wait_status(tcp_pkg::tcp_listening, 20);
    send(f_syn, r_seq, '0, our_port + 1'b1);
    expect_quiet("a SYN to a wrong port", 20);
    send(f_syn, r_seq, '0, our_port);
    r_seq = r_seq + 1;
    expect_seg("SYN-ACK", f_syn | f_ack, '0, r_seq, s);
    l_seq = s.seq + 1;
    send(f_ack, r_seq, '0, our_port);
    wait_status(tcp_pkg::tcp_connected, 20);
    check("loc_seq after passive open", loc_seq, l_seq);
    send(f_fin | f_ack, r_seq, '0, our_port);
    r_seq = r_seq + 1; // Peer FIN takes one number
    expect_seg("passive ACK", f_ack, l_seq, r_seq, s);
    expect_seg("passive FIN-ACK", f_fin | f_ack, l_seq, r_seq, s);
    l_seq = l_seq + 1;
    @(posedge clk);
    #5 ctl.listen = 1'b0; // Else the engine listens again
    send(f_ack, r_seq, '0, our_port);
    wait_status(tcp_pkg::tcp_closed, 20);

    ////////////////////
    // Peer reset, then an unanswered connect
    open_active();
    send(f_rst | f_ack, r_seq, '0, our_port);
    wait_status(tcp_pkg::tcp_disconnecting, 20);
    @(posedge clk);
    #5 ctl.connect = 1'b0;
    expect_seg("RST-ACK", f_rst | f_ack, l_seq, r_seq, s);
    wait_status(tcp_pkg::tcp_closed, 20);
    @(posedge clk);
    #5 ctl.connect = 1'b1;
    expect_seg("unanswered SYN", f_syn, '0, '0, s);
    @(posedge clk);
    #5 ctl.connect = 1'b0; // Engine is in SYN sent and ignores this
    repeat (`TCP_CONN_TIMEOUT - 100) @(negedge clk);
    check("status before the timeout", status, tcp_pkg::tcp_connecting);
    wait_status(tcp_pkg::tcp_closed, tmo_wait);

    repeat (10) @(posedge clk);
    afails = DUT.seg_queue_inst.asserts_inst.fails;
    $display("Checks done with %0d errors and %0d assertion failures", errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verif/tcp_conn_asserts.sv
`timescale 1ns/1ns
`include "tcp_params.svh"

module tcp_conn_asserts (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic req_accept,
  input logic tx_valid,
  input logic tx_credit
);

  localparam int occ_w = $clog2(`TCP_SEG_QUEUE_DEPTH + 1);

  int               fails = 0;  // Read by the testbench at the end
  logic             seen_req;   // Any request since reset
  logic [7:0]       avail;      // Credits granted and not yet spent
  logic [occ_w-1:0] occ;        // Segments accepted and not yet sent

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_req <= 1'b0;
      avail    <= 8'(`TCP_TX_CREDITS);
      occ      <= '0;
    end else begin
      if (req_valid) seen_req <= 1'b1;
      avail <= avail + 8'(tx_credit) - 8'(tx_valid);
      occ   <= occ + occ_w'(req_accept) - occ_w'(tx_valid);
    end
  end

  // Each emitted segment spends a credit that was there
  assert property (@(posedge clk) disable iff (rst) tx_valid |-> avail != 8'd0)
    else begin
      $error("tx_valid with no credit left");
      fails++;
    end

  assert property (@(posedge clk) disable iff (rst)
                   req_accept |-> occ != occ_w'(`TCP_SEG_QUEUE_DEPTH))
    else begin
      $error("req_accept while the queue was full");
      fails++;
    end

  // Nothing leaves before the first request
  assert property (@(posedge clk) disable iff (rst) !seen_req |-> !tx_valid)
    else begin
      $error("tx_valid before any request");
      fails++;
    end

endmodule

//--- hw/tcp_conn_top.sv
`timescale 1ns/1ns
`include "tcp_params.svh"

module tcp_conn_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           loc_ip,
  input  tcp_pkg::tcp_ctl_t     ctl,
  input  logic                  rx_valid,
  input  tcp_pkg::tcp_seg_t     rx_seg,
  input  logic                  tx_credit,
  output logic                  tx_valid,
  output tcp_pkg::tcp_seg_t     tx_seg,
  output tcp_pkg::tcp_status_t  status,
  output logic [`TCP_SEQ_W-1:0] rem_seq,
  output logic [`TCP_SEQ_W-1:0] loc_seq
);

  tcp_pkg::tcp_events_t   ev;
  tcp_pkg::tcp_seg_kind_t req_kind;
  logic [31:0]            isn;
  logic [15:0]            ip_id;
  logic [`TCP_SEQ_W-1:0]  req_seq;
  logic [`TCP_SEQ_W-1:0]  req_ack;
  logic [`TCP_PORT_W-1:0] conn_loc_port;
  logic [`TCP_PORT_W-1:0] conn_rem_port;
  logic [31:0]            rem_ip;
  logic                   req_valid;
  logic                   req_accept;
  logic                   sent;

  tcp_rx_classify rx_classify_inst (
    .clk           (clk),
    .rst           (rst),
    .rx_valid      (rx_valid),
    .rx_seg        (rx_seg),
    .listen_port   (ctl.loc_port),
    .conn_loc_port (conn_loc_port),
    .conn_rem_port (conn_rem_port),
    .ev            (ev)
  );

  tcp_isn_lfsr isn_lfsr_inst (
    .clk   (clk),
    .rst   (rst),
    .isn   (isn),
    .ip_id (ip_id)
  );

  tcp_conn_fsm conn_fsm_inst (
    .clk           (clk),
    .rst           (rst),
    .ctl           (ctl),
    .ev            (ev),
    .isn           (isn),
    .status        (status),
    .conn_loc_port (conn_loc_port),
    .conn_rem_port (conn_rem_port),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_seq       (req_seq),
    .req_ack       (req_ack),
    .req_accept    (req_accept),
    .sent          (sent),
    .rem_seq       (rem_seq),
    .loc_seq       (loc_seq),
    .rem_ip        (rem_ip)
  );

  tcp_seg_queue seg_queue_inst (
    .clk           (clk),
    .rst           (rst),
    .loc_ip        (loc_ip),
    .rem_ip        (rem_ip),
    .conn_loc_port (conn_loc_port),
    .conn_rem_port (conn_rem_port),
    .ip_id         (ip_id),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_seq       (req_seq),
    .req_ack       (req_ack),
    .req_accept    (req_accept),
    .sent          (sent),
    .tx_credit     (tx_credit),
    .tx_valid      (tx_valid),
    .tx_seg        (tx_seg)
  );

endmodule

//--- hw/tcp_seg_queue.sv
`timescale 1ns/1ns
`include "tcp_params.svh"

module tcp_seg_queue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [31:0]            loc_ip,
  input  logic [31:0]            rem_ip,
  input  logic [`TCP_PORT_W-1:0] conn_loc_port,
  input  logic [`TCP_PORT_W-1:0] conn_rem_port,
  input  logic [15:0]            ip_id,
  input  logic                   req_valid,
  input  tcp_pkg::tcp_seg_kind_t req_kind,
  input  logic [`TCP_SEQ_W-1:0]  req_seq,
  input  logic [`TCP_SEQ_W-1:0]  req_ack,
  output logic                   req_accept,
  output logic                   sent,
  input  logic                   tx_credit,
  output logic                   tx_valid,
  output tcp_pkg::tcp_seg_t      tx_seg
);

  localparam int depth = `TCP_SEG_QUEUE_DEPTH;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);
  localparam int crd_w = 8;

  tcp_pkg::tcp_seg_t mem [depth];
  tcp_pkg::tcp_seg_t new_seg;
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  count;
  logic [crd_w-1:0]  credits;
  logic              push;
  logic              pop;

  // Segment from the request
  always_comb begin
    new_seg.rem_ip   = rem_ip;
    new_seg.src_port = conn_loc_port;
    new_seg.dst_port = conn_rem_port;
    new_seg.seq      = req_seq;
    new_seg.ack      = req_ack;
    new_seg.len      = '0;
    new_seg.wnd      = 16'(`TCP_WINDOW);
    new_seg.ip_id    = ip_id ^ loc_ip[15:0]; // Salted per host
    new_seg.ttl      = 8'(`TCP_TTL);
    case (req_kind)
      tcp_pkg::kind_syn:     new_seg.flags.raw = tcp_pkg::tcp_flag_syn;
      tcp_pkg::kind_syn_ack: new_seg.flags.raw = tcp_pkg::tcp_flag_syn | tcp_pkg::tcp_flag_ack;
      tcp_pkg::kind_fin_ack: new_seg.flags.raw = tcp_pkg::tcp_flag_fin | tcp_pkg::tcp_flag_ack;
      tcp_pkg::kind_rst_ack: new_seg.flags.raw = tcp_pkg::tcp_flag_rst | tcp_pkg::tcp_flag_ack;
      default:               new_seg.flags.raw = tcp_pkg::tcp_flag_ack;
    endcase
  end

  // A held request is taken once, the cycle of its accept pulse is skipped
  assign push = req_valid && !req_accept && (count != cnt_w'(depth));
  assign pop  = (count != '0) && (credits != '0);
  assign sent = tx_valid;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= new_seg;
    if (pop)  tx_seg      <= mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= crd_w'(`TCP_TX_CREDITS);
      req_accept <= 1'b0;
      tx_valid   <= 1'b0;
    end else begin
      req_accept <= push;
      tx_valid   <= pop;
      if (push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      count   <= count + cnt_w'(push) - cnt_w'(pop);
      credits <= credits + crd_w'(tx_credit) - crd_w'(pop); // One spent per segment
    end
  end

endmodule

//--- hw/tcp_conn_fsm.sv
`timescale 1ns/1ns
`include "tcp_params.svh"

module tcp_conn_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  tcp_pkg::tcp_ctl_t       ctl,
  input  tcp_pkg::tcp_events_t    ev,
  input  logic [`TCP_SEQ_W-1:0]   isn,
  output tcp_pkg::tcp_status_t    status,
  output logic [`TCP_PORT_W-1:0]  conn_loc_port,
  output logic [`TCP_PORT_W-1:0]  conn_rem_port,
  output logic                    req_valid,
  output tcp_pkg::tcp_seg_kind_t  req_kind,
  output logic [`TCP_SEQ_W-1:0]   req_seq,
  output logic [`TCP_SEQ_W-1:0]   req_ack,
  input  logic                    req_accept,
  input  logic                    sent,
  output logic [`TCP_SEQ_W-1:0]   rem_seq,
  output logic [`TCP_SEQ_W-1:0]   loc_seq,
  output logic [31:0]             rem_ip
);

  localparam int tmr_w = $clog2(`TCP_CONN_TIMEOUT);

  typedef enum logic [3:0] {
    st_closed, st_listen,
    st_send_syn, st_syn_sent,
    st_send_syn_ack, st_syn_ack_sent,
    st_send_ack, st_established,
    st_send_fin, st_fin_sent,
    st_send_last_ack, st_last_ack_sent,
    st_send_rst
  } state_t;

  // Control block
  typedef struct packed {
    logic [31:0]            rem_ip;
    logic [`TCP_PORT_W-1:0] loc_port;
    logic [`TCP_PORT_W-1:0] rem_port;
    logic [`TCP_SEQ_W-1:0]  loc_seq;
    logic [`TCP_SEQ_W-1:0]  loc_ack;
    logic [`TCP_SEQ_W-1:0]  rem_seq; // Next sequence expected from the peer
    logic [`TCP_SEQ_W-1:0]  rem_ack;
  } tcb_t;

  state_t           state;
  tcb_t             tcb;
  logic             server;  // Opened by listen
  logic             passive; // Peer sent FIN first
  logic [tmr_w-1:0] tmr;
  logic             timed;
  logic             tmo;
  logic             usr_dcn;
  logic             conn_seg;

  assign timed = state inside {st_send_syn, st_syn_sent, st_send_syn_ack, st_syn_ack_sent,
                               st_send_fin, st_fin_sent, st_send_last_ack,
                               st_last_ack_sent, st_send_rst};
  assign tmo      = timed && (tmr == tmr_w'(`TCP_CONN_TIMEOUT - 1));
  assign usr_dcn  = server ? !ctl.listen : !ctl.connect;
  assign conn_seg = ev.ack || ev.fin || ev.rst || ev.data;

  // One counter serves both open and close
  always_ff @(posedge clk) begin
    if (rst || !timed) tmr <= '0;
    else               tmr <= tmr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst || tmo) begin
      state   <= st_closed;
      tcb     <= '0;
      server  <= 1'b0;
      passive <= 1'b0;
    end else begin
      case (state)
        st_closed: begin
          passive <= 1'b0;
          if (ctl.listen) begin
            server <= 1'b1;
            state  <= st_listen;
          end else if (ctl.connect) begin
            server       <= 1'b0;
            tcb.rem_ip   <= ctl.rem_ip;
            tcb.loc_port <= ctl.loc_port;
            tcb.rem_port <= ctl.rem_port;
            tcb.loc_seq  <= isn;
            state        <= st_send_syn;
          end
        end
        ////////////////////
        // Active open
        st_send_syn: if (req_accept) state <= st_syn_sent;
        st_syn_sent: begin
          if (ev.syn_ack && ev.seg.src_port == tcb.rem_port) begin
            tcb.loc_seq <= tcb.loc_seq + 1'b1; // SYN uses one number
            tcb.loc_ack <= ev.seg.seq + 1'b1;
            tcb.rem_seq <= ev.seg.seq + 1'b1;
            tcb.rem_ack <= ev.seg.ack;
            state       <= st_send_ack;
          end
        end
        ////////////////////
        // Passive open
        st_listen: begin
          if (!ctl.listen) begin
            state <= st_closed;
          end else if (ev.syn) begin
            tcb.rem_ip   <= ev.seg.rem_ip;
            tcb.loc_port <= ctl.loc_port;
            tcb.rem_port <= ev.seg.src_port;
            tcb.loc_seq  <= isn;
            tcb.loc_ack  <= ev.seg.seq + 1'b1;
            tcb.rem_seq  <= ev.seg.seq;
            tcb.rem_ack  <= ev.seg.ack;
            state        <= st_send_syn_ack;
          end
        end
        st_send_syn_ack: if (req_accept) state <= st_syn_ack_sent;
        st_syn_ack_sent: begin
          if (ev.ack && ev.seg.seq == tcb.rem_seq + 1'b1) begin
            tcb.loc_seq <= tcb.loc_seq + 1'b1;
            tcb.rem_seq <= ev.seg.seq;
            tcb.rem_ack <= ev.seg.ack;
            state       <= st_established;
          end
        end
        ////////////////////
        // Established
        st_send_ack: if (req_accept) state <= st_established; // Handshake or data ACK
        st_established: begin
          if (conn_seg) begin
            tcb.rem_seq <= ev.seg.seq + ev.seg.len;
            tcb.rem_ack <= ev.seg.ack;
          end
          if (usr_dcn) begin
            state <= st_send_fin;
          end else if (ev.rst) begin
            state <= st_send_rst;
          end else if (ev.fin) begin
            passive     <= 1'b1;
            tcb.loc_ack <= ev.seg.seq + 1'b1;
            state       <= st_send_last_ack;
          end else if (ev.data) begin
            tcb.loc_ack <= ev.seg.seq + ev.seg.len;
            state       <= st_send_ack;
          end
        end
        ////////////////////
        // Closing
        st_send_fin: begin
          if (req_accept) begin
            tcb.loc_seq <= tcb.loc_seq + 1'b1; // FIN uses one number
            state       <= st_fin_sent;
          end
        end
        st_fin_sent: begin
          if (conn_seg) tcb.rem_ack <= ev.seg.ack;
          if (passive) begin
            // Peer ACK of our FIN ends a passive close
            if (ev.ack && ev.seg.ack == tcb.loc_seq) begin
              tcb   <= '0;
              state <= st_closed;
            end
          end else if (ev.fin && (ev.seg.ack == tcb.loc_seq || tcb.rem_ack == tcb.loc_seq)) begin
            tcb.loc_ack <= ev.seg.seq + 1'b1;
            state       <= st_send_last_ack;
          end
        end
        st_send_last_ack: if (req_accept) state <= st_last_ack_sent;
        st_last_ack_sent: begin
          if (sent) begin
            if (passive) begin
              state <= st_send_fin; // Our own FIN follows the ACK
            end else begin
              tcb   <= '0;
              state <= st_closed;
            end
          end
        end
        st_send_rst: begin
          if (req_accept) begin
            tcb   <= '0;
            state <= st_closed;
          end
        end
        default: state <= st_closed;
      endcase
    end
  end

  always_comb begin
    case (state)
      st_closed:      status = tcp_pkg::tcp_closed;
      st_listen:      status = tcp_pkg::tcp_listening;
      st_send_ack,
      st_established: status = tcp_pkg::tcp_connected;
      st_send_fin,
      st_fin_sent,
      st_send_last_ack,
      st_last_ack_sent,
      st_send_rst:    status = tcp_pkg::tcp_disconnecting;
      default:        status = tcp_pkg::tcp_connecting;
    endcase
  end

  ////////////////////
  // Segment requests
  assign req_valid = state inside {st_send_syn, st_send_syn_ack, st_send_ack, st_send_fin,
                                   st_send_last_ack, st_send_rst};

  always_comb begin
    case (state)
      st_send_syn:     req_kind = tcp_pkg::kind_syn;
      st_send_syn_ack: req_kind = tcp_pkg::kind_syn_ack;
      st_send_fin:     req_kind = tcp_pkg::kind_fin_ack;
      st_send_rst:     req_kind = tcp_pkg::kind_rst_ack;
      default:         req_kind = tcp_pkg::kind_ack;
    endcase
  end

  assign req_seq       = tcb.loc_seq;
  assign req_ack       = tcb.loc_ack; // Still zero while the SYN is out
  assign rem_seq       = tcb.rem_seq;
  assign loc_seq       = tcb.loc_seq;
  assign rem_ip        = tcb.rem_ip;
  assign conn_loc_port = tcb.loc_port;
  assign conn_rem_port = tcb.rem_port;

endmodule

//--- hw/tcp_rx_classify.sv
`timescale 1ns/1ns
`include "tcp_params.svh"

module tcp_rx_classify (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rx_valid,
  input  tcp_pkg::tcp_seg_t      rx_seg,
  input  logic [`TCP_PORT_W-1:0] listen_port,
  input  logic [`TCP_PORT_W-1:0] conn_loc_port,
  input  logic [`TCP_PORT_W-1:0] conn_rem_port,
  output tcp_pkg::tcp_events_t   ev
);

  logic loc_hit;  // Addressed to the port in user control
  logic conn_hit; // Belongs to the current connection

  assign loc_hit  = rx_valid && (rx_seg.dst_port == listen_port);
  assign conn_hit = rx_valid && (rx_seg.src_port == conn_rem_port) &&
                    (rx_seg.dst_port == conn_loc_port);

  always_ff @(posedge clk) begin
    if (rst) begin
      ev.syn     <= 1'b0;
      ev.syn_ack <= 1'b0;
      ev.ack     <= 1'b0;
      ev.fin     <= 1'b0;
      ev.rst     <= 1'b0;
      ev.data    <= 1'b0;
    end else begin
      // Only a bare SYN opens a passive connection
      ev.syn     <= loc_hit && (rx_seg.flags.raw == tcp_pkg::tcp_flag_syn);
      ev.syn_ack <= loc_hit && rx_seg.flags.bits.syn && rx_seg.flags.bits.ack;
      ev.ack     <= conn_hit && rx_seg.flags.bits.ack;
      ev.fin     <= conn_hit && rx_seg.flags.bits.fin;
      ev.rst     <= conn_hit && rx_seg.flags.bits.rst;
      ev.data    <= conn_hit && (rx_seg.len != '0);
    end
    if (rx_valid) ev.seg <= rx_seg; // Held until the next arrival
  end

endmodule

//--- hw/tcp_isn_lfsr.sv
`timescale 1ns/1ns

module tcp_isn_lfsr (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] isn,
  output logic [15:0] ip_id
);

  localparam logic [31:0] poly = 32'h8020_0003; // Taps 32, 22, 2, 1
  localparam logic [31:0] seed = 32'h1d87_2b41;

  logic [31:0] state;

  // Galois form, one step per clock
  always_ff @(posedge clk) begin
    if (rst) state <= seed;
    else     state <= (state >> 1) ^ (state[0] ? poly : 32'h0);
  end

  assign isn   = state;
  assign ip_id = state[15:0];

endmodule

//--- hw/tcp_pkg.sv
`include "tcp_params.svh"

package tcp_pkg;

  // Flag bits in header order
  typedef struct packed {
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  // Same six bits seen as single flags or as one code
  typedef union packed {
    tcp_flags_t bits;
    logic [5:0] raw;
  } tcp_flags_u;

  localparam logic [5:0] tcp_flag_fin = 6'b00_0001;
  localparam logic [5:0] tcp_flag_syn = 6'b00_0010;
  localparam logic [5:0] tcp_flag_rst = 6'b00_0100;
  localparam logic [5:0] tcp_flag_ack = 6'b01_0000;

  typedef struct packed {
    logic [31:0]            rem_ip;   // Source on receive, destination on transmit
    logic [`TCP_PORT_W-1:0] src_port;
    logic [`TCP_PORT_W-1:0] dst_port;
    logic [`TCP_SEQ_W-1:0]  seq;
    logic [`TCP_SEQ_W-1:0]  ack;
    tcp_flags_u             flags;
    logic [`TCP_LEN_W-1:0]  len;      // Payload bytes
    logic [15:0]            wnd;
    logic [15:0]            ip_id;
    logic [7:0]             ttl;
  } tcp_seg_t;

  // User control, held as levels
  typedef struct packed {
    logic                   connect;
    logic                   listen;
    logic [`TCP_PORT_W-1:0] loc_port;
    logic [31:0]            rem_ip;
    logic [`TCP_PORT_W-1:0] rem_port;
  } tcp_ctl_t;

  typedef enum logic [2:0] {
    tcp_closed,
    tcp_listening,
    tcp_connecting,
    tcp_connected,
    tcp_disconnecting
  } tcp_status_t;

  typedef struct packed {
    logic     syn;
    logic     syn_ack;
    logic     ack;
    logic     fin;
    logic     rst;
    logic     data;
    tcp_seg_t seg;
  } tcp_events_t;

  typedef enum logic [2:0] {
    kind_syn,
    kind_syn_ack,
    kind_ack,
    kind_fin_ack,
    kind_rst_ack
  } tcp_seg_kind_t;

endpackage

//--- hw/tcp_params.svh
`ifndef TCP_PARAMS_SVH
`define TCP_PARAMS_SVH

// Field widths
`define TCP_PORT_W 16
`define TCP_SEQ_W 32
`define TCP_LEN_W 16

// Cycles an open or close may take before it is abandoned
`define TCP_CONN_TIMEOUT 3000

// Outgoing segment queue
`define TCP_SEG_QUEUE_DEPTH 4
`define TCP_TX_CREDITS 2 // Granted by the transmit side after reset

// Header constants for outgoing segments
`define TCP_WINDOW 1000
`define TCP_TTL 64

`endif
